// ==== design/lc4_core.sv ====
`timescale 1ns/1ps

module lc4_core (
   input  logic              i_reset,
   input  logic              gwe,
   output lc4_pkg::word_t    o_imem_addr,
   input  lc4_pkg::word_t    i_imem_rdata,
   output lc4_pkg::word_t    o_dmem_addr,
   input  lc4_pkg::word_t    i_dmem_rdata,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_dmem_wdata,
   output lc4_pkg::reg_sel_t o_wb_rd_sel,
   output logic              o_wb_rd_we,
   output lc4_pkg::word_t    o_wb_data,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output lc4_pkg::stall_t   o_wb_stall,
   output lc4_pkg::nzp_t     o_wb_nzp_bits,
   output logic              o_wb_nzp_we,
   output logic              o_wb_dmem_we,
   output lc4_pkg::word_t    o_wb_dmem_addr,
   output lc4_pkg::word_t    o_wb_dmem_data
);

   logic              stall;
   lc4_pkg::word_t    id_insn, id_pc, imm, rs_data, rt_data;
   lc4_pkg::stall_t   id_stall, mem_stall;
   lc4_pkg::reg_sel_t rs_sel, rt_sel, rd_sel;
   logic              rs_re, rt_re, rd_we, is_load, is_store;
   lc4_pkg::alu_op_t  alu_op;
   lc4_pkg::fwd_sel_t fwd_rs, fwd_rt;
   lc4_pkg::reg_sel_t ex_rd_sel, ex_rs_sel, ex_rt_sel, mem_rd_sel;
   logic              ex_rd_we, ex_is_load;
   lc4_pkg::word_t    mem_pc, mem_insn, mem_result, mem_store_data, mem_fwd_data;
   logic              mem_rd_we, mem_is_load, mem_is_store;

   lc4_fetch u_fetch (
      .i_reset(i_reset), .gwe(gwe), .i_stall(stall), .i_imem_rdata(i_imem_rdata),
      .o_imem_addr(o_imem_addr), .o_id_insn(id_insn), .o_id_pc(id_pc), .o_id_stall(id_stall)
   );

   lc4_decoder u_decoder (
      .i_insn(id_insn), .o_rs_sel(rs_sel), .o_rt_sel(rt_sel), .o_rd_sel(rd_sel),
      .o_rs_re(rs_re), .o_rt_re(rt_re), .o_rd_we(rd_we), .o_is_load(is_load),
      .o_is_store(is_store), .o_alu_op(alu_op), .o_imm(imm)
   );

   // write port is fed from the WB stage
   lc4_regfile u_regfile (
      .i_reset(i_reset), .gwe(gwe), .i_rs_sel(rs_sel), .i_rt_sel(rt_sel),
      .i_rd_sel(o_wb_rd_sel), .i_rd_we(o_wb_rd_we), .i_rd_data(o_wb_data),
      .o_rs_data(rs_data), .o_rt_data(rt_data)
   );

   lc4_hazard_ctrl u_hazard (
      .i_id_rs_sel(rs_sel), .i_id_rt_sel(rt_sel), .i_id_rs_re(rs_re), .i_id_rt_re(rt_re),
      .i_ex_rd_sel(ex_rd_sel), .i_ex_rd_we(ex_rd_we), .i_ex_is_load(ex_is_load),
      .i_ex_rs_sel(ex_rs_sel), .i_ex_rt_sel(ex_rt_sel),
      .i_mem_rd_sel(mem_rd_sel), .i_mem_rd_we(mem_rd_we),
      .i_wb_rd_sel(o_wb_rd_sel), .i_wb_rd_we(o_wb_rd_we),
      .o_stall(stall), .o_fwd_rs(fwd_rs), .o_fwd_rt(fwd_rt)
   );

   lc4_execute u_execute (
      .i_reset(i_reset), .gwe(gwe), .i_stall(stall),
      .i_rs_sel(rs_sel), .i_rt_sel(rt_sel), .i_rd_sel(rd_sel), .i_rs_re(rs_re),
      .i_rt_re(rt_re), .i_rd_we(rd_we), .i_is_load(is_load), .i_is_store(is_store),
      .i_alu_op(alu_op), .i_imm(imm), .i_id_pc(id_pc), .i_id_insn(id_insn),
      .i_id_stall(id_stall), .i_rs_data(rs_data), .i_rt_data(rt_data),
      .i_fwd_rs(fwd_rs), .i_fwd_rt(fwd_rt), .i_mem_fwd_data(mem_fwd_data),
      .i_wb_data(o_wb_data), .o_ex_rd_sel(ex_rd_sel), .o_ex_rd_we(ex_rd_we),
      .o_ex_is_load(ex_is_load), .o_ex_rs_sel(ex_rs_sel), .o_ex_rt_sel(ex_rt_sel),
      .o_mem_pc(mem_pc), .o_mem_insn(mem_insn), .o_mem_rd_sel(mem_rd_sel),
      .o_mem_rd_we(mem_rd_we), .o_mem_is_load(mem_is_load), .o_mem_is_store(mem_is_store),
      .o_mem_result(mem_result), .o_mem_store_data(mem_store_data), .o_mem_stall(mem_stall)
   );

   lc4_mem_wb u_mem_wb (
      .i_reset(i_reset), .gwe(gwe), .i_mem_pc(mem_pc), .i_mem_insn(mem_insn),
      .i_mem_rd_sel(mem_rd_sel), .i_mem_rd_we(mem_rd_we), .i_mem_is_load(mem_is_load),
      .i_mem_is_store(mem_is_store), .i_mem_result(mem_result),
      .i_mem_store_data(mem_store_data), .i_mem_stall(mem_stall),
      .i_dmem_rdata(i_dmem_rdata), .o_dmem_addr(o_dmem_addr), .o_dmem_wdata(o_dmem_wdata),
      .o_dmem_we(o_dmem_we), .o_mem_fwd_data(mem_fwd_data),
      .o_wb_rd_sel(o_wb_rd_sel), .o_wb_rd_we(o_wb_rd_we), .o_wb_data(o_wb_data),
      .o_wb_pc(o_wb_pc), .o_wb_insn(o_wb_insn), .o_wb_stall(o_wb_stall),
      .o_wb_nzp_bits(o_wb_nzp_bits), .o_wb_nzp_we(o_wb_nzp_we),
      .o_wb_dmem_we(o_wb_dmem_we), .o_wb_dmem_addr(o_wb_dmem_addr),
      .o_wb_dmem_data(o_wb_dmem_data)
   );

endmodule

// ==== design/lc4_decoder.sv ====
`timescale 1ns/1ps

module lc4_decoder (
   input  lc4_pkg::word_t    i_insn,
   output lc4_pkg::reg_sel_t o_rs_sel,
   output lc4_pkg::reg_sel_t o_rt_sel,
   output lc4_pkg::reg_sel_t o_rd_sel,
   output logic              o_rs_re,
   output logic              o_rt_re,
   output logic              o_rd_we,
   output logic              o_is_load,
   output logic              o_is_store,
   output lc4_pkg::alu_op_t  o_alu_op,
   output lc4_pkg::word_t    o_imm
);

   lc4_pkg::opcode_t opcode;
   logic [2:0]       sub_op;

   assign opcode   = i_insn[15:12];
   assign sub_op   = i_insn[5:3];
   assign o_rs_sel = i_insn[8:6];
   assign o_rd_sel = i_insn[11:9];

   always_comb begin
      o_rt_sel   = i_insn[2:0];
      o_rs_re    = 1'b0;
      o_rt_re    = 1'b0;
      o_rd_we    = 1'b0;
      o_is_load  = 1'b0;
      o_is_store = 1'b0;
      o_alu_op   = lc4_pkg::ALU_PASS_B;
      o_imm      = '0;
      case (opcode)
         lc4_pkg::OP_ARITH: begin
            if (i_insn[5]) begin            // add immediate with imm5
               o_rs_re  = 1'b1;
               o_rd_we  = 1'b1;
               o_alu_op = lc4_pkg::ALU_ADD;
               o_imm    = {{11{i_insn[4]}}, i_insn[4:0]};
            end else if (sub_op != 3'b011) begin  // div falls through as a nop
               o_rs_re = 1'b1;
               o_rt_re = 1'b1;
               o_rd_we = 1'b1;
               case (sub_op[1:0])
                  2'b00:   o_alu_op = lc4_pkg::ALU_ADD;
                  2'b01:   o_alu_op = lc4_pkg::ALU_MUL;
                  default: o_alu_op = lc4_pkg::ALU_SUB;
               endcase
            end
         end
         lc4_pkg::OP_LOGIC: begin
            o_rs_re = 1'b1;
            o_rd_we = 1'b1;
            if (i_insn[5]) begin
               o_alu_op = lc4_pkg::ALU_AND;
               o_imm    = {{11{i_insn[4]}}, i_insn[4:0]};
            end else begin
               o_rt_re = (sub_op != 3'b001);  // not has one source
               case (sub_op[1:0])
                  2'b00:   o_alu_op = lc4_pkg::ALU_AND;
                  2'b01:   o_alu_op = lc4_pkg::ALU_NOT;
                  2'b10:   o_alu_op = lc4_pkg::ALU_OR;
                  default: o_alu_op = lc4_pkg::ALU_XOR;
               endcase
            end
         end
         lc4_pkg::OP_LDR, lc4_pkg::OP_STR: begin
            // address is rs + imm6; a store reads its data from insn[11:9]
            o_rs_re    = 1'b1;
            o_alu_op   = lc4_pkg::ALU_ADD;
            o_imm      = {{10{i_insn[5]}}, i_insn[5:0]};
            o_is_load  = (opcode == lc4_pkg::OP_LDR);
            o_is_store = (opcode == lc4_pkg::OP_STR);
            o_rd_we    = (opcode == lc4_pkg::OP_LDR);
            o_rt_re    = (opcode == lc4_pkg::OP_STR);
            o_rt_sel   = i_insn[11:9];
         end
         lc4_pkg::OP_CONST: begin
            o_rd_we = 1'b1;
            o_imm   = {{7{i_insn[8]}}, i_insn[8:0]};
         end
         default: ;  // nop and unsupported encodings keep every enable low
      endcase
   end

endmodule

// ==== design/lc4_execute.sv ====
`timescale 1ns/1ps

module lc4_execute (
   input  logic              i_reset,
   input  logic              gwe,
   input  logic              i_stall,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   input  lc4_pkg::reg_sel_t i_rd_sel,
   input  logic              i_rs_re,
   input  logic              i_rt_re,
   input  logic              i_rd_we,
   input  logic              i_is_load,
   input  logic              i_is_store,
   input  lc4_pkg::alu_op_t  i_alu_op,
   input  lc4_pkg::word_t    i_imm,
   input  lc4_pkg::word_t    i_id_pc,
   input  lc4_pkg::word_t    i_id_insn,
   input  lc4_pkg::stall_t   i_id_stall,
   input  lc4_pkg::word_t    i_rs_data,
   input  lc4_pkg::word_t    i_rt_data,
   input  lc4_pkg::fwd_sel_t i_fwd_rs,
   input  lc4_pkg::fwd_sel_t i_fwd_rt,
   input  lc4_pkg::word_t    i_mem_fwd_data,
   input  lc4_pkg::word_t    i_wb_data,
   output lc4_pkg::reg_sel_t o_ex_rd_sel,
   output logic              o_ex_rd_we,
   output logic              o_ex_is_load,
   output lc4_pkg::reg_sel_t o_ex_rs_sel,
   output lc4_pkg::reg_sel_t o_ex_rt_sel,
   output lc4_pkg::word_t    o_mem_pc,
   output lc4_pkg::word_t    o_mem_insn,
   output lc4_pkg::reg_sel_t o_mem_rd_sel,
   output logic              o_mem_rd_we,
   output logic              o_mem_is_load,
   output logic              o_mem_is_store,
   output lc4_pkg::word_t    o_mem_result,
   output lc4_pkg::word_t    o_mem_store_data,
   output lc4_pkg::stall_t   o_mem_stall
);

   lc4_pkg::word_t   ex_pc, ex_insn, ex_imm, ex_rs_data, ex_rt_data;
   lc4_pkg::alu_op_t ex_alu_op;
   lc4_pkg::stall_t  ex_stall;
   logic             ex_rs_re, ex_rt_re, ex_is_store;
   lc4_pkg::word_t   rs_fwd, rt_fwd, op_a, op_b, alu_result;

   // a stall turns the ID/EX slot into a bubble
   always_ff @(posedge gwe) begin
      if (i_reset || i_stall) begin
         ex_rs_re     <= 1'b0;
         ex_rt_re     <= 1'b0;
         o_ex_rd_we   <= 1'b0;
         o_ex_is_load <= 1'b0;
         ex_is_store  <= 1'b0;
         ex_insn      <= {lc4_pkg::OP_NOP, 12'h000};
         ex_stall     <= i_reset ? lc4_pkg::STALL_RESET : lc4_pkg::STALL_LOAD;
      end else begin
         ex_rs_re     <= i_rs_re;
         ex_rt_re     <= i_rt_re;
         o_ex_rd_we   <= i_rd_we;
         o_ex_is_load <= i_is_load;
         ex_is_store  <= i_is_store;
         ex_insn      <= i_id_insn;
         ex_stall     <= i_id_stall;
      end
   end

   always_ff @(posedge gwe) begin
      ex_pc       <= i_id_pc;
      o_ex_rs_sel <= i_rs_sel;
      o_ex_rt_sel <= i_rt_sel;
      o_ex_rd_sel <= i_rd_sel;
      ex_alu_op   <= i_alu_op;
      ex_imm      <= i_imm;
      ex_rs_data  <= i_rs_data;
      ex_rt_data  <= i_rt_data;
   end

   function automatic lc4_pkg::word_t bypass(input lc4_pkg::fwd_sel_t sel,
                                             input lc4_pkg::word_t    reg_val);
      case (sel)
         lc4_pkg::FWD_MEM: bypass = i_mem_fwd_data;   // MX
         lc4_pkg::FWD_WB:  bypass = i_wb_data;        // WX
         default:          bypass = reg_val;
      endcase
   endfunction

   assign rs_fwd = bypass(i_fwd_rs, ex_rs_data);
   assign rt_fwd = bypass(i_fwd_rt, ex_rt_data);
   assign op_a   = ex_rs_re ? rs_fwd : '0;
   assign op_b   = (ex_rt_re && !ex_is_store) ? rt_fwd : ex_imm;  // stores add imm6

   always_comb begin
      case (ex_alu_op)
         lc4_pkg::ALU_ADD: alu_result = op_a + op_b;
         lc4_pkg::ALU_MUL: alu_result = op_a * op_b;   // low half of the product
         lc4_pkg::ALU_SUB: alu_result = op_a - op_b;
         lc4_pkg::ALU_AND: alu_result = op_a & op_b;
         lc4_pkg::ALU_NOT: alu_result = ~op_a;
         lc4_pkg::ALU_OR:  alu_result = op_a | op_b;
         lc4_pkg::ALU_XOR: alu_result = op_a ^ op_b;
         default:          alu_result = op_b;          // const
      endcase
   end

   // EX/MEM
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_mem_rd_we    <= 1'b0;
         o_mem_is_load  <= 1'b0;
         o_mem_is_store <= 1'b0;
         o_mem_insn     <= {lc4_pkg::OP_NOP, 12'h000};
         o_mem_stall    <= lc4_pkg::STALL_RESET;
      end else begin
         o_mem_rd_we    <= o_ex_rd_we;
         o_mem_is_load  <= o_ex_is_load;
         o_mem_is_store <= ex_is_store;
         o_mem_insn     <= ex_insn;
         o_mem_stall    <= ex_stall;
      end
   end

   always_ff @(posedge gwe) begin
      o_mem_pc         <= ex_pc;
      o_mem_rd_sel     <= o_ex_rd_sel;
      o_mem_result     <= alu_result;
      o_mem_store_data <= rt_fwd;
   end

endmodule

// ==== design/lc4_fetch.sv ====
`timescale 1ns/1ps

module lc4_fetch (
   input  logic            i_reset,
   input  logic            gwe,
   input  logic            i_stall,
   input  lc4_pkg::word_t  i_imem_rdata,
   output lc4_pkg::word_t  o_imem_addr,
   output lc4_pkg::word_t  o_id_insn,
   output lc4_pkg::word_t  o_id_pc,
   output lc4_pkg::stall_t o_id_stall
);

   lc4_pkg::word_t pc;

   assign o_imem_addr = pc;  // imem answers in the same cycle

   // pc and IF/ID both freeze on a load-use stall
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         pc         <= lc4_pkg::RESET_PC;
         o_id_insn  <= {lc4_pkg::OP_NOP, 12'h000};
         o_id_stall <= lc4_pkg::STALL_RESET;
      end else if (!i_stall) begin
         pc         <= pc + 16'd1;
         o_id_insn  <= i_imem_rdata;
         o_id_stall <= lc4_pkg::STALL_NONE;
      end
   end

   always_ff @(posedge gwe) begin
      if (!i_stall) o_id_pc <= pc;
   end

endmodule

// ==== design/lc4_hazard_ctrl.sv ====
`timescale 1ns/1ps

module lc4_hazard_ctrl (
   input  lc4_pkg::reg_sel_t i_id_rs_sel,
   input  lc4_pkg::reg_sel_t i_id_rt_sel,
   input  logic              i_id_rs_re,
   input  logic              i_id_rt_re,
   input  lc4_pkg::reg_sel_t i_ex_rd_sel,
   input  logic              i_ex_rd_we,
   input  logic              i_ex_is_load,
   input  lc4_pkg::reg_sel_t i_ex_rs_sel,
   input  lc4_pkg::reg_sel_t i_ex_rt_sel,
   input  lc4_pkg::reg_sel_t i_mem_rd_sel,
   input  logic              i_mem_rd_we,
   input  lc4_pkg::reg_sel_t i_wb_rd_sel,
   input  logic              i_wb_rd_we,
   output logic              o_stall,
   output lc4_pkg::fwd_sel_t o_fwd_rs,
   output lc4_pkg::fwd_sel_t o_fwd_rt
);

   logic rs_hit;
   logic rt_hit;

   // load data only exists at the end of MEM, so a direct consumer waits a cycle
   assign rs_hit  = i_id_rs_re && (i_id_rs_sel == i_ex_rd_sel);
   assign rt_hit  = i_id_rt_re && (i_id_rt_sel == i_ex_rd_sel);
   assign o_stall = i_ex_is_load && i_ex_rd_we && (rs_hit || rt_hit);

   // youngest producer wins
   always_comb begin
      o_fwd_rs = lc4_pkg::FWD_REG;
      if (i_mem_rd_we && i_mem_rd_sel == i_ex_rs_sel) begin
         o_fwd_rs = lc4_pkg::FWD_MEM;
      end else if (i_wb_rd_we && i_wb_rd_sel == i_ex_rs_sel) begin
         o_fwd_rs = lc4_pkg::FWD_WB;
      end
   end

   always_comb begin
      o_fwd_rt = lc4_pkg::FWD_REG;
      if (i_mem_rd_we && i_mem_rd_sel == i_ex_rt_sel) begin
         o_fwd_rt = lc4_pkg::FWD_MEM;
      end else if (i_wb_rd_we && i_wb_rd_sel == i_ex_rt_sel) begin
         o_fwd_rt = lc4_pkg::FWD_WB;
      end
   end

endmodule

// ==== design/lc4_mem_wb.sv ====
`timescale 1ns/1ps

module lc4_mem_wb (
   input  logic              i_reset,
   input  logic              gwe,
   input  lc4_pkg::word_t    i_mem_pc,
   input  lc4_pkg::word_t    i_mem_insn,
   input  lc4_pkg::reg_sel_t i_mem_rd_sel,
   input  logic              i_mem_rd_we,
   input  logic              i_mem_is_load,
   input  logic              i_mem_is_store,
   input  lc4_pkg::word_t    i_mem_result,
   input  lc4_pkg::word_t    i_mem_store_data,
   input  lc4_pkg::stall_t   i_mem_stall,
   input  lc4_pkg::word_t    i_dmem_rdata,
   output lc4_pkg::word_t    o_dmem_addr,
   output lc4_pkg::word_t    o_dmem_wdata,
   output logic              o_dmem_we,
   output lc4_pkg::word_t    o_mem_fwd_data,
   output lc4_pkg::reg_sel_t o_wb_rd_sel,
   output logic              o_wb_rd_we,
   output lc4_pkg::word_t    o_wb_data,
   output lc4_pkg::word_t    o_wb_pc,
   output lc4_pkg::word_t    o_wb_insn,
   output lc4_pkg::stall_t   o_wb_stall,
   output lc4_pkg::nzp_t     o_wb_nzp_bits,
   output logic              o_wb_nzp_we,
   output logic              o_wb_dmem_we,
   output lc4_pkg::word_t    o_wb_dmem_addr,
   output lc4_pkg::word_t    o_wb_dmem_data
);

   logic           mem_access;
   lc4_pkg::word_t trace_data;

   assign mem_access     = i_mem_is_load || i_mem_is_store;
   assign o_dmem_addr    = mem_access ? i_mem_result : '0;
   assign o_dmem_wdata   = i_mem_store_data;
   assign o_dmem_we      = i_mem_is_store;
   assign o_mem_fwd_data = i_mem_is_load ? i_dmem_rdata : i_mem_result;  // writeback value
   assign trace_data     = i_mem_is_load  ? i_dmem_rdata :
                           i_mem_is_store ? i_mem_store_data : '0;

   // MEM/WB
   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_wb_rd_we   <= 1'b0;
         o_wb_dmem_we <= 1'b0;
         o_wb_insn    <= {lc4_pkg::OP_NOP, 12'h000};
         o_wb_stall   <= lc4_pkg::STALL_RESET;
      end else begin
         o_wb_rd_we   <= i_mem_rd_we;
         o_wb_dmem_we <= i_mem_is_store;
         o_wb_insn    <= i_mem_insn;
         o_wb_stall   <= i_mem_stall;
      end
   end

   always_ff @(posedge gwe) begin
      o_wb_pc        <= i_mem_pc;
      o_wb_rd_sel    <= i_mem_rd_sel;
      o_wb_data      <= o_mem_fwd_data;
      o_wb_dmem_addr <= o_dmem_addr;
      o_wb_dmem_data <= trace_data;
   end

   assign o_wb_nzp_we   = o_wb_rd_we;
   assign o_wb_nzp_bits = o_wb_data[15]      ? 3'b100 :
                          (o_wb_data == '0)  ? 3'b010 : 3'b001;

endmodule

// ==== design/lc4_pkg.sv ====
package lc4_pkg;

   typedef logic [15:0] word_t;     // data, address and instruction word
   typedef logic [2:0]  reg_sel_t;
   typedef logic [2:0]  nzp_t;      // ordered n, z, p
   typedef logic [3:0]  alu_op_t;
   typedef logic [3:0]  opcode_t;
   typedef logic [1:0]  fwd_sel_t;
   typedef logic [1:0]  stall_t;

   localparam word_t RESET_PC = 16'h8200;
   localparam int    NUM_REGS = 8;

   // opcode field in insn[15:12]
   localparam opcode_t OP_NOP   = 4'b0000;
   localparam opcode_t OP_ARITH = 4'b0001;
   localparam opcode_t OP_LOGIC = 4'b0101;
   localparam opcode_t OP_LDR   = 4'b0110;
   localparam opcode_t OP_STR   = 4'b0111;
   localparam opcode_t OP_CONST = 4'b1001;

   localparam alu_op_t ALU_ADD    = 4'd0;
   localparam alu_op_t ALU_MUL    = 4'd1;
   localparam alu_op_t ALU_SUB    = 4'd2;
   localparam alu_op_t ALU_AND    = 4'd3;
   localparam alu_op_t ALU_NOT    = 4'd4;
   localparam alu_op_t ALU_OR     = 4'd5;
   localparam alu_op_t ALU_XOR    = 4'd6;
   localparam alu_op_t ALU_PASS_B = 4'd7;  // result is operand b

   // execute operand source
   localparam fwd_sel_t FWD_REG = 2'd0;
   localparam fwd_sel_t FWD_MEM = 2'd1;
   localparam fwd_sel_t FWD_WB  = 2'd2;

   // trace stall codes
   localparam stall_t STALL_NONE  = 2'd0;
   localparam stall_t STALL_RESET = 2'd2;
   localparam stall_t STALL_LOAD  = 2'd3;

endpackage

// ==== design/lc4_regfile.sv ====
`timescale 1ns/1ps

module lc4_regfile (
   input  logic              i_reset,
   input  logic              gwe,
   input  lc4_pkg::reg_sel_t i_rs_sel,
   input  lc4_pkg::reg_sel_t i_rt_sel,
   input  lc4_pkg::reg_sel_t i_rd_sel,
   input  logic              i_rd_we,
   input  lc4_pkg::word_t    i_rd_data,
   output lc4_pkg::word_t    o_rs_data,
   output lc4_pkg::word_t    o_rt_data
);

   lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_rd_data;
      end
   end

   // write-through so decode sees the value retiring this cycle
   assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
   assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

// ==== dv/lc4_core_tb.sv ====
`timescale 1ns/1ps

module lc4_core_tb;

   localparam int RAND_LEN = 200;

   logic                i_reset;
   logic                gwe = 1'b0;
   lc4_pkg::word_t      o_imem_addr, i_imem_rdata, o_dmem_addr, i_dmem_rdata, o_dmem_wdata;
   logic                o_dmem_we, o_wb_rd_we, o_wb_nzp_we, o_wb_dmem_we;
   lc4_pkg::reg_sel_t   o_wb_rd_sel;
   lc4_pkg::word_t      o_wb_data, o_wb_pc, o_wb_insn, o_wb_dmem_addr, o_wb_dmem_data;
   lc4_pkg::stall_t     o_wb_stall;
   lc4_pkg::nzp_t       o_wb_nzp_bits;

   logic [15:0] imem [0:65535];
   logic [15:0] dmem [0:65535];
   logic [15:0] ref_mem [0:65535];   // model copy of data memory
   logic [15:0] ref_regs [0:7];
   int          prog_len = 0;
   int          n_directed = 0;
   int          retired = 0;
   int          bubbles = 0;         // STALL_LOAD cycles since the last retire
   int          errors = 0;
   logic        build_done = 1'b0;
   logic        prev_load = 1'b0;
   logic [2:0]  prev_rd = 3'd0;
   logic [15:0] ref_pc = lc4_pkg::RESET_PC;
   logic [31:0] lcg_state = 32'he8d78974;
   string       section = "reset";
   logic        port_we = 1'b0;      // memory-stage port values of the previous cycle
   logic [15:0] port_addr = 16'h0000;
   logic [15:0] port_wdata = 16'h0000;

   lc4_core i_dut (.*);

   always #50 gwe = ~gwe;

   // same-cycle memories
   assign i_imem_rdata = imem[o_imem_addr];
   assign i_dmem_rdata = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (!i_reset && o_dmem_we) dmem[o_dmem_addr] = o_dmem_wdata;
   end

   function automatic int lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'(lcg_state[30:16]);
   endfunction

   function automatic logic [15:0] fill_word(input logic [15:0] a);
      return (a * 16'h9e37) ^ 16'hc3a5;
   endfunction

   function automatic logic [15:0] rrr(input logic [3:0] op, input int rd, input int rs,
                                       input int sub, input int rt);
      return {op, 3'(rd), 3'(rs), 3'(sub), 3'(rt)};
   endfunction

   function automatic logic [15:0] rri(input logic [3:0] op, input int rd, input int rs,
                                       input int imm);
      return {op, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
   endfunction

   function automatic logic [15:0] ldst(input logic [3:0] op, input int r, input int rs,
                                        input int imm);
      return {op, 3'(r), 3'(rs), 6'(imm)};
   endfunction

   function automatic logic [15:0] cnst(input int rd, input int imm);
      return {4'b1001, 3'(rd), 9'(imm)};
   endfunction

   task automatic append(input logic [15:0] insn);
      imem[lc4_pkg::RESET_PC + 16'(prog_len)] = insn;
      prog_len++;
   endtask

   // ISA register reads that predict the load-use bubble
   function automatic logic reads_reg(input logic [15:0] insn, input logic [2:0] r);
      case (insn[15:12])
         4'b0001: return insn[8:6] == r || (!insn[5] && insn[2:0] == r);
         4'b0101: return insn[8:6] == r || (!insn[5] && insn[5:3] != 3'd1 && insn[2:0] == r);
         4'b0110: return insn[8:6] == r;
         4'b0111: return insn[8:6] == r || insn[11:9] == r;
         default: return 1'b0;
      endcase
   endfunction

   // executes one instruction on the model state
   function automatic void ref_exec(input logic [15:0] insn, output logic we,
                                    output logic [15:0] val, output logic st,
                                    output logic [15:0] addr, output logic [15:0] mdata);
      logic [15:0] a, b, i5, i6, i9;
      logic [2:0]  sub;
      a     = ref_regs[insn[8:6]];
      b     = ref_regs[insn[2:0]];
      sub   = insn[5:3];
      i5    = {{11{insn[4]}}, insn[4:0]};
      i6    = {{10{insn[5]}}, insn[5:0]};
      i9    = {{7{insn[8]}}, insn[8:0]};
      we    = 1'b0;
      val   = '0;
      st    = 1'b0;
      addr  = '0;
      mdata = '0;
      case (insn[15:12])
         4'b0001: begin
            we = 1'b1;
            if (insn[5]) val = a + i5;
            else if (sub == 3'd0) val = a + b;
            else if (sub == 3'd1) val = a * b;
            else if (sub == 3'd2) val = a - b;
            else we = 1'b0;   // div and the rest do nothing
         end
         4'b0101: begin
            we = 1'b1;
            if (insn[5]) val = a & i5;
            else if (sub == 3'd0) val = a & b;
            else if (sub == 3'd1) val = ~a;
            else if (sub == 3'd2) val = a | b;
            else if (sub == 3'd3) val = a ^ b;
            else we = 1'b0;
         end
         4'b0110: begin
            addr  = a + i6;
            val   = ref_mem[addr];
            mdata = val;
            we    = 1'b1;
         end
         4'b0111: begin
            addr  = a + i6;
            mdata = ref_regs[insn[11:9]];
            st    = 1'b1;
            ref_mem[addr] = mdata;
         end
         4'b1001: begin
            val = i9;
            we  = 1'b1;
         end
         default: ;
      endcase
      if (we) ref_regs[insn[11:9]] = val;
   endfunction

   task automatic check(input string field, input int exp, input int act);
      if (exp != act) begin
         errors++;
         $display("FAILED %s %s expected %h actual %h", section, field, exp, act);
      end
   endtask

   always @(negedge gwe) begin
      logic        e_we, e_st, mem_op;
      logic [15:0] e_val, e_addr, e_data, insn;
      int          e_bub;
      if (!i_reset) begin
         if (o_wb_stall == lc4_pkg::STALL_RESET) begin
            if (retired != 0 || o_wb_rd_we || o_wb_nzp_we || o_wb_dmem_we) begin
               errors++;
               $display("reset trace cycle seen late or with a write enable set");
            end
         end else if (o_wb_stall == lc4_pkg::STALL_LOAD) begin
            bubbles++;
            if (o_wb_rd_we || o_wb_nzp_we || o_wb_dmem_we) begin
               errors++;
               $display("load-use bubble retired with a write enable set");
            end
         end else begin
            insn    = imem[ref_pc];
            section = (retired < n_directed) ? "directed" : "random";
            e_bub   = (prev_load && reads_reg(insn, prev_rd)) ? 1 : 0;
            ref_exec(insn, e_we, e_val, e_st, e_addr, e_data);
            mem_op  = (insn[15:12] == 4'b0110) || e_st;
            check("pc", int'(ref_pc), int'(o_wb_pc));
            check("insn", int'(insn), int'(o_wb_insn));
            check("rd_we", int'(e_we), int'(o_wb_rd_we));
            check("nzp_we", int'(e_we), int'(o_wb_nzp_we));
            if (e_we) begin
               check("rd_sel", int'(insn[11:9]), int'(o_wb_rd_sel));
               check("data", int'(e_val), int'(o_wb_data));
               // sign and zero rule on the written value
               check("nzp", e_val[15] ? 4 : (e_val == 16'd0 ? 2 : 1), int'(o_wb_nzp_bits));
            end
            check("dmem_we", int'(e_st), int'(o_wb_dmem_we));
            check("dmem_addr", int'(e_addr), int'(o_wb_dmem_addr));
            check("dmem_data", int'(e_data), int'(o_wb_dmem_data));
            check("port_dmem_we", int'(e_st), int'(port_we));
            if (mem_op) begin
               check("port_dmem_addr", int'(e_addr), int'(port_addr));
            end
            if (e_st) begin
               check("port_dmem_wdata", int'(e_data), int'(port_wdata));
            end
            check("bubbles", e_bub, bubbles);
            prev_load = (insn[15:12] == 4'b0110);
            prev_rd   = insn[11:9];
            bubbles   = 0;
            ref_pc++;
            retired++;
         end
      end
      port_we    = o_dmem_we;
      port_addr  = o_dmem_addr;
      port_wdata = o_dmem_wdata;
   end

   // watchdog allows ten cycles per instruction plus twenty
   initial begin
      wait (build_done);
      #((prog_len * 10 + 20) * 100);
      $display("timeout after %0d of %0d instructions retired", retired, prog_len);
      $display("errors: %0d, instructions retired: %0d", errors, retired);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      int kind;
      int rd;
      i_reset = 1'b1;
      for (int a = 0; a < 65536; a++) begin
         imem[a]    = 16'h0000;
         dmem[a]    = fill_word(16'(a));
         ref_mem[a] = fill_word(16'(a));
      end
      for (int r = 0; r < 8; r++) ref_regs[r] = 16'h0000;

      // dependent chain at distances 0, 1 and 2
      append(cnst(1, 5));
      append(cnst(2, -3));
      append(rrr(4'b0001, 3, 1, 0, 2));
      append(rrr(4'b0001, 4, 3, 2, 1));
      append(cnst(6, 7));
      append(rrr(4'b0001, 5, 4, 1, 3));
      append(cnst(7, 0));
      append(cnst(0, 1));
      append(rrr(4'b0101, 6, 5, 0, 6));
      append(rrr(4'b0101, 7, 6, 2, 3));
      append(rrr(4'b0101, 0, 7, 3, 2));
      append(rrr(4'b0101, 1, 0, 1, 0));
      append(rri(4'b0001, 2, 1, -1));
      append(rri(4'b0101, 3, 2, 12));
      append(rrr(4'b0001, 4, 1, 2, 1));    // zero result
      // store, load, load-use and a consumer two slots later
      append(cnst(5, 32));
      append(ldst(4'b0111, 2, 5, 3));
      append(ldst(4'b0110, 6, 5, 3));
      append(rrr(4'b0001, 7, 6, 0, 6));
      append(ldst(4'b0110, 1, 5, 3));
      append(16'h0000);
      append(rrr(4'b0001, 2, 1, 0, 1));
      append(ldst(4'b0110, 3, 5, -4));
      append(ldst(4'b0111, 3, 5, 9));      // store data from a load
      append(cnst(0, 64));                 // base for the random window
      n_directed = prog_len;

      for (int k = 0; k < RAND_LEN; k++) begin
         kind = lcg_next() % 8;
         rd   = 1 + lcg_next() % 7;
         case (kind)
            0, 1: append(rrr(4'b0001, rd, lcg_next() % 8, lcg_next() % 3, lcg_next() % 8));
            2, 3: append(rrr(4'b0101, rd, lcg_next() % 8, lcg_next() % 4, lcg_next() % 8));
            4: append(rri((lcg_next() % 2 == 0) ? 4'b0001 : 4'b0101, rd, lcg_next() % 8,
                          lcg_next() % 32));
            5: append(cnst(rd, lcg_next() % 512));
            6: append(ldst(4'b0110, rd, 0, lcg_next() % 64));
            default: append(ldst(4'b0111, lcg_next() % 8, 0, lcg_next() % 64));
         endcase
      end
      build_done = 1'b1;

      repeat (2) @(posedge gwe);
      #1 i_reset = 1'b0;
      #1;
      if (o_imem_addr != lc4_pkg::RESET_PC) begin
         errors++;
         $display("FAILED reset imem_addr expected %h actual %h", lc4_pkg::RESET_PC,
                  o_imem_addr);
      end

      wait (retired >= prog_len);
      $display("errors: %0d, instructions retired: %0d", errors, retired);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== lc4_core.f ====
design/lc4_pkg.sv
design/lc4_fetch.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
design/lc4_hazard_ctrl.sv
design/lc4_execute.sv
design/lc4_mem_wb.sv
design/lc4_core.sv
dv/lc4_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f lc4_core.f --top-module lc4_core_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

out=$(./obj_dir/Vlc4_core_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^Result: PASSED$"; then
   exit 0
fi
exit 1
